// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= id_stage_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
src/id_pkg.sv
src/if_id_reg.sv
src/regfile.sv
src/operand_forward.sv
src/inst_decoder.sv
src/branch_unit.sv
src/id_stage.sv
tests/tb_clock.sv
tests/id_stage_tb.sv

// File: src/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  id_pkg::br_kind_e br_kind,
    input  id_pkg::word_t    pc,
    input  logic [15:0]      imm,
    input  logic [25:0]      instr_index,
    input  id_pkg::word_t    data1,
    input  id_pkg::word_t    data2,
    output id_pkg::br_t      br
);
    import id_pkg::*;

    word_t rel_target;
    word_t abs_target;

    assign rel_target = pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
    assign abs_target = {pc[31:28], instr_index, 2'b00};   // same 256 MB region

    always_comb begin
        br.taken  = 1'b0;
        br.target = '0;
        case (br_kind)
            br_eq, br_ne, br_lez, br_gtz, br_ltz, br_gez: begin
                br.target = rel_target;
                case (br_kind)
                    br_eq:   br.taken = (data1 == data2);
                    br_ne:   br.taken = (data1 != data2);
                    br_lez:  br.taken = ($signed(data1) <= 0);
                    br_gtz:  br.taken = ($signed(data1) > 0);
                    br_ltz:  br.taken = ($signed(data1) < 0);
                    default: br.taken = ($signed(data1) >= 0);
                endcase
            end
            br_jabs: begin
                br.taken  = 1'b1;
                br.target = abs_target;
            end
            br_jreg: begin
                br.taken  = 1'b1;
                br.target = data1;   // bypassed rs
            end
            default: ;
        endcase
    end

endmodule

// File: src/id_pkg.sv
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // the three instruction formats
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] instr_index;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
        word_t  raw;
    } instr_u;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } fetch_t;

    typedef struct packed {
        logic id_stop;
        logic ex_stop;
    } stall_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        logic      is_load;
        rf_write_t wr;
    } ex_fwd_t;

    typedef struct packed {
        logic op_add, op_sub, op_slt, op_sltu;
        logic op_and, op_nor, op_or, op_xor;
        logic op_sll, op_srl, op_sra, op_lui;
    } alu_op_t;

    typedef struct packed {
        logic sa;   // shift amount, zero extended
        logic pc;
        logic rs;
    } src1_sel_t;

    typedef struct packed {
        logic imm_zext;
        logic const8;   // link offset for jal
        logic imm_sext;
        logic rt;
    } src2_sel_t;

    typedef enum logic [3:0] {
        br_none, br_eq, br_ne, br_lez, br_gtz, br_ltz, br_gez, br_jabs, br_jreg
    } br_kind_e;

    typedef struct packed {
        word_t      pc;
        word_t      inst;
        alu_op_t    alu_op;
        src1_sel_t  src1_sel;
        src2_sel_t  src2_sel;
        logic       ram_en;
        logic [3:0] ram_wen;
        logic       rf_we;
        reg_addr_t  rf_waddr;
        logic       rf_from_mem;   // result comes from data memory
        word_t      data1;
        word_t      data2;
    } id_to_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

    // primary opcodes
    localparam logic [5:0] opc_special = 6'b000000;
    localparam logic [5:0] opc_regimm  = 6'b000001;
    localparam logic [5:0] opc_j       = 6'b000010;
    localparam logic [5:0] opc_jal     = 6'b000011;
    localparam logic [5:0] opc_beq     = 6'b000100;
    localparam logic [5:0] opc_bne     = 6'b000101;
    localparam logic [5:0] opc_blez    = 6'b000110;
    localparam logic [5:0] opc_bgtz    = 6'b000111;
    localparam logic [5:0] opc_addi    = 6'b001000;
    localparam logic [5:0] opc_addiu   = 6'b001001;
    localparam logic [5:0] opc_slti    = 6'b001010;
    localparam logic [5:0] opc_sltiu   = 6'b001011;
    localparam logic [5:0] opc_andi    = 6'b001100;
    localparam logic [5:0] opc_ori     = 6'b001101;
    localparam logic [5:0] opc_xori    = 6'b001110;
    localparam logic [5:0] opc_lui     = 6'b001111;
    localparam logic [5:0] opc_lw      = 6'b100011;
    localparam logic [5:0] opc_sw      = 6'b101011;

    // special function codes
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_sllv = 6'b000100;
    localparam logic [5:0] fn_srlv = 6'b000110;
    localparam logic [5:0] fn_srav = 6'b000111;
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_add  = 6'b100000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_sub  = 6'b100010;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    // regimm selectors in the rt field
    localparam reg_addr_t rt_bltz = 5'b00000;
    localparam reg_addr_t rt_bgez = 5'b00001;

    localparam reg_addr_t link_reg = 5'd31;

endpackage

// File: src/id_stage.sv
`timescale 1ns/10ps

module id_stage (
    input  logic              clk,
    input  logic              rst,
    input  id_pkg::fetch_t    fetch,
    input  id_pkg::stall_t    stall,
    input  id_pkg::word_t     inst_rdata,
    input  id_pkg::rf_write_t wb,
    input  id_pkg::ex_fwd_t   ex_fwd,
    input  id_pkg::rf_write_t mem_fwd,
    output id_pkg::id_to_ex_t id_to_ex,
    output id_pkg::br_t       br,
    output logic              stall_load
);
    import id_pkg::*;

    fetch_t     fetch_q;
    instr_u     inst;
    alu_op_t    alu_op;
    src1_sel_t  src1_sel;
    src2_sel_t  src2_sel;
    logic       ram_en;
    logic [3:0] ram_wen;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    logic       rf_from_mem;
    logic       use1;
    logic       use2;
    br_kind_e   br_kind;
    word_t      rdata1;
    word_t      rdata2;
    word_t      data1;
    word_t      data2;

    assign inst.raw = inst_rdata;   // arrives one cycle after the fetch pc

    if_id_reg if_id_reg_inst (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .fetch   (fetch),
        .fetch_q (fetch_q)
    );

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (inst.r.rs),
        .raddr2 (inst.r.rt),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (wb)
    );

    inst_decoder inst_decoder_inst (
        .inst        (inst),
        .valid       (fetch_q.valid),
        .alu_op      (alu_op),
        .src1_sel    (src1_sel),
        .src2_sel    (src2_sel),
        .ram_en      (ram_en),
        .ram_wen     (ram_wen),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_from_mem (rf_from_mem),
        .use1        (use1),
        .use2        (use2),
        .br_kind     (br_kind)
    );

    operand_forward operand_forward_inst (
        .rs         (inst.r.rs),
        .rt         (inst.r.rt),
        .use1       (use1),
        .use2       (use2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb         (wb),
        .data1      (data1),
        .data2      (data2),
        .stall_load (stall_load)
    );

    branch_unit branch_unit_inst (
        .br_kind     (br_kind),
        .pc          (fetch_q.pc),
        .imm         (inst.i.imm),
        .instr_index (inst.j.instr_index),
        .data1       (data1),
        .data2       (data2),
        .br          (br)
    );

    assign id_to_ex = '{
        pc:          fetch_q.pc,
        inst:        inst.raw,
        alu_op:      alu_op,
        src1_sel:    src1_sel,
        src2_sel:    src2_sel,
        ram_en:      ram_en,
        ram_wen:     ram_wen,
        rf_we:       rf_we,
        rf_waddr:    rf_waddr,
        rf_from_mem: rf_from_mem,
        data1:       data1,
        data2:       data2
    };

endmodule

// File: src/if_id_reg.sv
`timescale 1ns/10ps

module if_id_reg (
    input  logic           clk,
    input  logic           rst,
    input  id_pkg::stall_t stall,
    input  id_pkg::fetch_t fetch,
    output id_pkg::fetch_t fetch_q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_q <= '0;
        end else if (stall.id_stop && !stall.ex_stop) begin
            fetch_q <= '0;       // bubble into execute
        end else if (!stall.id_stop) begin
            fetch_q <= fetch;
        end                      // else hold
    end

    // a fresh pipeline must not decode whatever sits on the instruction bus
    valid_clear_after_rst: assert property (@(posedge clk) rst |=> !fetch_q.valid)
        else $error("if_id_reg: valid high in the cycle after reset");

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  id_pkg::instr_u    inst,
    input  logic              valid,
    output id_pkg::alu_op_t   alu_op,
    output id_pkg::src1_sel_t src1_sel,
    output id_pkg::src2_sel_t src2_sel,
    output logic              ram_en,
    output logic [3:0]        ram_wen,
    output logic              rf_we,
    output id_pkg::reg_addr_t rf_waddr,
    output logic              rf_from_mem,
    output logic              use1,
    output logic              use2,
    output id_pkg::br_kind_e  br_kind
);
    import id_pkg::*;

    logic sa_shift;

    assign sa_shift = (inst.r.funct[5:2] == 4'b0000);   // sll, srl, sra use sa

    always_comb begin
        alu_op      = '0;
        src1_sel    = '0;
        src2_sel    = '0;
        ram_en      = 1'b0;
        ram_wen     = '0;
        rf_we       = 1'b0;
        rf_waddr    = '0;
        rf_from_mem = 1'b0;
        use1        = 1'b0;
        use2        = 1'b0;
        br_kind     = br_none;
        if (valid) begin
            case (inst.r.opcode)
                opc_special: begin
                    case (inst.r.funct)
                        fn_add, fn_addu:        alu_op.op_add  = 1'b1;
                        fn_sub, fn_subu:        alu_op.op_sub  = 1'b1;
                        fn_slt:                 alu_op.op_slt  = 1'b1;
                        fn_sltu:                alu_op.op_sltu = 1'b1;
                        fn_and:                 alu_op.op_and  = 1'b1;
                        fn_nor:                 alu_op.op_nor  = 1'b1;
                        fn_or:                  alu_op.op_or   = 1'b1;
                        fn_xor:                 alu_op.op_xor  = 1'b1;
                        fn_sll, fn_sllv:        alu_op.op_sll  = 1'b1;
                        fn_srl, fn_srlv:        alu_op.op_srl  = 1'b1;
                        fn_sra, fn_srav:        alu_op.op_sra  = 1'b1;
                        fn_jr: begin
                            use1    = 1'b1;
                            br_kind = br_jreg;
                        end
                        default: ;
                    endcase
                    if (alu_op != '0) begin   // R-type result to rd
                        rf_we       = 1'b1;
                        rf_waddr    = inst.r.rd;
                        src2_sel.rt = 1'b1;
                        use2        = 1'b1;
                        src1_sel.sa = sa_shift;
                        src1_sel.rs = !sa_shift;
                        use1        = !sa_shift;
                    end
                end
                opc_addi, opc_addiu, opc_slti, opc_sltiu,
                opc_andi, opc_ori, opc_xori, opc_lui: begin
                    rf_we             = 1'b1;
                    rf_waddr          = inst.i.rt;
                    src1_sel.rs       = (inst.i.opcode != opc_lui);
                    use1              = (inst.i.opcode != opc_lui);
                    src2_sel.imm_zext = (inst.i.opcode inside {opc_andi, opc_ori, opc_xori});
                    src2_sel.imm_sext = !src2_sel.imm_zext;
                    case (inst.i.opcode)
                        opc_addi, opc_addiu: alu_op.op_add  = 1'b1;
                        opc_slti:            alu_op.op_slt  = 1'b1;
                        opc_sltiu:           alu_op.op_sltu = 1'b1;
                        opc_andi:            alu_op.op_and  = 1'b1;
                        opc_ori:             alu_op.op_or   = 1'b1;
                        opc_xori:            alu_op.op_xor  = 1'b1;
                        default:             alu_op.op_lui  = 1'b1;
                    endcase
                end
                opc_lw, opc_sw: begin
                    alu_op.op_add     = 1'b1;   // address = base + offset
                    src1_sel.rs       = 1'b1;
                    src2_sel.imm_sext = 1'b1;
                    use1              = 1'b1;
                    ram_en            = 1'b1;
                    if (inst.i.opcode == opc_sw) begin
                        ram_wen = 4'b1111;
                        use2    = 1'b1;         // store data from rt
                    end else begin
                        rf_we       = 1'b1;
                        rf_waddr    = inst.i.rt;
                        rf_from_mem = 1'b1;
                    end
                end
                opc_beq, opc_bne: begin
                    use1    = 1'b1;
                    use2    = 1'b1;
                    br_kind = (inst.i.opcode == opc_beq) ? br_eq : br_ne;
                end
                opc_blez: begin
                    use1    = 1'b1;
                    br_kind = br_lez;
                end
                opc_bgtz: begin
                    use1    = 1'b1;
                    br_kind = br_gtz;
                end
                opc_regimm: begin
                    case (inst.i.rt)
                        rt_bltz: begin
                            use1    = 1'b1;
                            br_kind = br_ltz;
                        end
                        rt_bgez: begin
                            use1    = 1'b1;
                            br_kind = br_gez;
                        end
                        default: ;              // linking forms not supported
                    endcase
                end
                opc_j: br_kind = br_jabs;
                opc_jal: begin
                    br_kind         = br_jabs;
                    alu_op.op_add   = 1'b1;     // link value pc + 8
                    src1_sel.pc     = 1'b1;
                    src2_sel.const8 = 1'b1;
                    rf_we           = 1'b1;
                    rf_waddr        = link_reg;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        assert final ($onehot0(alu_op))
            else $error("inst_decoder: more than one ALU operation selected");
    end

endmodule

// File: src/operand_forward.sv
`timescale 1ns/10ps

module operand_forward (
    input  id_pkg::reg_addr_t rs,
    input  id_pkg::reg_addr_t rt,
    input  logic              use1,
    input  logic              use2,
    input  id_pkg::word_t     rdata1,
    input  id_pkg::word_t     rdata2,
    input  id_pkg::ex_fwd_t   ex_fwd,
    input  id_pkg::rf_write_t mem_fwd,
    input  id_pkg::rf_write_t wb,
    output id_pkg::word_t     data1,
    output id_pkg::word_t     data2,
    output logic              stall_load
);
    import id_pkg::*;

    // youngest producer wins
    function automatic word_t pick(input reg_addr_t addr, input word_t rf_data);
        if (addr == '0) return '0;
        if (ex_fwd.wr.we && ex_fwd.wr.waddr == addr) return ex_fwd.wr.wdata;
        if (mem_fwd.we && mem_fwd.waddr == addr) return mem_fwd.wdata;
        if (wb.we && wb.waddr == addr) return wb.wdata;   // same-cycle write
        return rf_data;
    endfunction

    always_comb begin
        data1 = pick(rs, rdata1);
        data2 = pick(rt, rdata2);
    end

    // load data only exists after the memory stage
    assign stall_load = ex_fwd.is_load && ex_fwd.wr.we && (ex_fwd.wr.waddr != '0) &&
                        ((use1 && ex_fwd.wr.waddr == rs) ||
                         (use2 && ex_fwd.wr.waddr == rt));

    always_comb begin
        assert final (!stall_load || ex_fwd.is_load)
            else $error("operand_forward: stall raised without a load in execute");
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    input  id_pkg::rf_write_t wr
);
    import id_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // $0 is hardwired, entry 0 is never written
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: tests/id_stage_tb.sv
`timescale 1ns/10ps

module id_stage_tb;
    import id_pkg::*;

    localparam int num_cycles  = 4000;
    localparam int fill_cycles = 31;

    localparam logic [5:0] r_functs [17] = '{
        fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav, fn_jr, fn_add, fn_addu,
        fn_sub, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu
    };
    localparam logic [5:0] i_opcodes [8] = '{
        opc_addi, opc_addiu, opc_slti, opc_sltiu, opc_andi, opc_ori, opc_xori, opc_lui
    };
    localparam logic [5:0] br_opcodes [4] = '{opc_beq, opc_bne, opc_blez, opc_bgtz};
    localparam logic [5:0] bad_functs [4] = '{6'b000001, 6'b001100, 6'b011000, 6'b111111};

    logic      clk;
    logic      rst;
    fetch_t    fetch;
    stall_t    stall;
    word_t     inst_rdata;
    rf_write_t wb;
    ex_fwd_t   ex_fwd;
    rf_write_t mem_fwd;
    id_to_ex_t id_to_ex;
    br_t       br;
    logic      stall_load;

    // reference model state
    word_t       model_regs [32];
    fetch_t      model_q;
    id_to_ex_t   exp;
    logic        exp_use1;
    logic        exp_use2;
    br_kind_e    exp_kind;
    logic [15:0] lfsr_state = 16'd48;
    int          errors;
    int          checks;

    tb_clock clock_gen (
        .clk (clk),
        .rst (rst)
    );

    id_stage id_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .stall      (stall),
        .inst_rdata (inst_rdata),
        .wb         (wb),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .id_to_ex   (id_to_ex),
        .br         (br),
        .stall_load (stall_load)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic word_t random_instr();
        instr_u w;
        int     sel;
        w.raw = take_bits(32);
        sel = int'(take_bits(5));
        if (sel < 10) begin
            w.r.opcode = opc_special;
            w.r.funct  = r_functs[int'(take_bits(5)) % 17];
        end else if (sel < 18) begin
            w.i.opcode = i_opcodes[sel - 10];
        end else if (sel < 20) begin
            w.i.opcode = (sel == 18) ? opc_lw : opc_sw;
        end else if (sel < 24) begin
            w.i.opcode = br_opcodes[sel - 20];
        end else if (sel < 26) begin
            w.i.opcode = opc_regimm;
            w.i.rt     = (sel == 24) ? rt_bltz : rt_bgez;
        end else if (sel < 28) begin
            w.j.opcode = (sel == 26) ? opc_j : opc_jal;
        end else if (sel < 30) begin
            w.i.opcode = {1'(take_bits(1)), 1'b1, 4'(take_bits(4))};   // 01xxxx or 11xxxx
        end else if (sel == 30) begin
            w.r.opcode = opc_special;
            w.r.funct  = bad_functs[int'(take_bits(2))];
        end else begin
            w.i.opcode = opc_regimm;
            w.i.rt     = {1'b1, 4'(take_bits(4))};   // linking and other regimm forms
        end
        return w.raw;
    endfunction

    // aim writes at the operands so bypass hits are frequent
    function automatic reg_addr_t pick_dest(input instr_u w);
        logic [1:0] k;
        k = 2'(take_bits(2));
        if (k == 2'd0) return w.r.rs;
        if (k == 2'd1) return w.r.rt;
        if (k == 2'd2) return '0;
        return 5'(take_bits(5));
    endfunction

    task automatic drive_inputs();
        instr_u w;
        w.raw = random_instr();
        inst_rdata       = w.raw;
        stall.id_stop    = (take_bits(2) == 0);
        stall.ex_stop    = 1'(take_bits(1));
        fetch.valid      = (take_bits(3) != 0);
        fetch.pc         = take_bits(30) << 2;
        ex_fwd.is_load   = 1'(take_bits(1));
        ex_fwd.wr.we     = 1'(take_bits(1));
        ex_fwd.wr.waddr  = pick_dest(w);
        ex_fwd.wr.wdata  = take_bits(32);
        mem_fwd.we       = 1'(take_bits(1));
        mem_fwd.waddr    = pick_dest(w);
        mem_fwd.wdata    = take_bits(32);
        wb.we            = 1'(take_bits(1));
        wb.waddr         = pick_dest(w);
        wb.wdata         = take_bits(32);
    endtask

    task automatic model_decode(input instr_u w, input logic valid);
        logic by_sa;
        exp      = '0;
        exp_use1 = 1'b0;
        exp_use2 = 1'b0;
        exp_kind = br_none;
        if (valid) begin
            case (w.r.opcode)
                opc_special: begin
                    case (w.r.funct)
                        fn_add, fn_addu: exp.alu_op.op_add  = 1'b1;
                        fn_sub, fn_subu: exp.alu_op.op_sub  = 1'b1;
                        fn_slt:          exp.alu_op.op_slt  = 1'b1;
                        fn_sltu:         exp.alu_op.op_sltu = 1'b1;
                        fn_and:          exp.alu_op.op_and  = 1'b1;
                        fn_nor:          exp.alu_op.op_nor  = 1'b1;
                        fn_or:           exp.alu_op.op_or   = 1'b1;
                        fn_xor:          exp.alu_op.op_xor  = 1'b1;
                        fn_sll, fn_sllv: exp.alu_op.op_sll  = 1'b1;
                        fn_srl, fn_srlv: exp.alu_op.op_srl  = 1'b1;
                        fn_sra, fn_srav: exp.alu_op.op_sra  = 1'b1;
                        default: ;
                    endcase
                    by_sa = (w.r.funct == fn_sll) || (w.r.funct == fn_srl) ||
                            (w.r.funct == fn_sra);
                    if (w.r.funct == fn_jr) begin
                        exp_use1 = 1'b1;
                        exp_kind = br_jreg;
                    end else if (exp.alu_op != '0) begin
                        exp.rf_we       = 1'b1;
                        exp.rf_waddr    = w.r.rd;
                        exp.src1_sel.sa = by_sa;
                        exp.src1_sel.rs = !by_sa;
                        exp.src2_sel.rt = 1'b1;
                        exp_use1        = !by_sa;
                        exp_use2        = 1'b1;
                    end
                end
                opc_addi, opc_addiu, opc_slti, opc_sltiu,
                opc_andi, opc_ori, opc_xori, opc_lui: begin
                    exp.rf_we    = 1'b1;
                    exp.rf_waddr = w.i.rt;
                    case (w.i.opcode)
                        opc_addi, opc_addiu: exp.alu_op.op_add  = 1'b1;
                        opc_slti:            exp.alu_op.op_slt  = 1'b1;
                        opc_sltiu:           exp.alu_op.op_sltu = 1'b1;
                        opc_andi:            exp.alu_op.op_and  = 1'b1;
                        opc_ori:             exp.alu_op.op_or   = 1'b1;
                        opc_xori:            exp.alu_op.op_xor  = 1'b1;
                        default:             exp.alu_op.op_lui  = 1'b1;
                    endcase
                    // logical immediates are zero extended
                    if (exp.alu_op.op_and || exp.alu_op.op_or || exp.alu_op.op_xor)
                        exp.src2_sel.imm_zext = 1'b1;
                    else
                        exp.src2_sel.imm_sext = 1'b1;
                    if (!exp.alu_op.op_lui) begin
                        exp.src1_sel.rs = 1'b1;
                        exp_use1        = 1'b1;
                    end
                end
                opc_lw, opc_sw: begin
                    exp.alu_op.op_add     = 1'b1;
                    exp.src1_sel.rs       = 1'b1;
                    exp.src2_sel.imm_sext = 1'b1;
                    exp.ram_en            = 1'b1;
                    exp_use1              = 1'b1;
                    if (w.i.opcode == opc_sw) begin
                        exp.ram_wen = 4'b1111;
                        exp_use2    = 1'b1;
                    end else begin
                        exp.rf_we       = 1'b1;
                        exp.rf_waddr    = w.i.rt;
                        exp.rf_from_mem = 1'b1;
                    end
                end
                opc_beq: begin
                    exp_use1 = 1'b1;
                    exp_use2 = 1'b1;
                    exp_kind = br_eq;
                end
                opc_bne: begin
                    exp_use1 = 1'b1;
                    exp_use2 = 1'b1;
                    exp_kind = br_ne;
                end
                opc_blez: begin
                    exp_use1 = 1'b1;
                    exp_kind = br_lez;
                end
                opc_bgtz: begin
                    exp_use1 = 1'b1;
                    exp_kind = br_gtz;
                end
                opc_regimm: begin
                    exp_use1 = (w.i.rt == rt_bltz) || (w.i.rt == rt_bgez);
                    if (w.i.rt == rt_bltz) exp_kind = br_ltz;
                    if (w.i.rt == rt_bgez) exp_kind = br_gez;
                end
                opc_j: exp_kind = br_jabs;
                opc_jal: begin
                    exp_kind              = br_jabs;
                    exp.alu_op.op_add     = 1'b1;   // pc + 8 into $31
                    exp.src1_sel.pc       = 1'b1;
                    exp.src2_sel.const8   = 1'b1;
                    exp.rf_we             = 1'b1;
                    exp.rf_waddr          = link_reg;
                end
                default: ;
            endcase
        end
    endtask

    // execute, memory, writeback, then the mirrored register file
    function automatic word_t model_operand(input reg_addr_t a);
        if (a == '0) return '0;
        if (ex_fwd.wr.we && ex_fwd.wr.waddr == a) return ex_fwd.wr.wdata;
        if (mem_fwd.we && mem_fwd.waddr == a) return mem_fwd.wdata;
        if (wb.we && wb.waddr == a) return wb.wdata;
        return model_regs[a];
    endfunction

    function automatic logic [30:0] ctrl_bits(input id_to_ex_t x);
        return {x.alu_op, x.src1_sel, x.src2_sel, x.ram_en, x.ram_wen,
                x.rf_we, x.rf_waddr, x.rf_from_mem};
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] want);
        errors++;
        $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, want);
    endtask

    task automatic check_outputs();
        instr_u w;
        word_t  op1;
        word_t  op2;
        word_t  offset;
        word_t  want_target;
        logic   want_taken;
        logic   want_stall;
        w.raw = inst_rdata;
        model_decode(w, model_q.valid);
        op1    = model_operand(w.r.rs);
        op2    = model_operand(w.r.rt);
        offset = {{16{w.i.imm[15]}}, w.i.imm};
        want_taken  = 1'b0;
        want_target = '0;
        case (exp_kind)
            br_eq:   want_taken = (op1 == op2);
            br_ne:   want_taken = (op1 != op2);
            br_lez:  want_taken = ($signed(op1) <= 0);
            br_gtz:  want_taken = ($signed(op1) > 0);
            br_ltz:  want_taken = ($signed(op1) < 0);
            br_gez:  want_taken = ($signed(op1) >= 0);
            default: want_taken = (exp_kind == br_jabs) || (exp_kind == br_jreg);
        endcase
        if (exp_kind == br_jabs)
            want_target = {model_q.pc[31:28], w.j.instr_index, 2'b00};
        else if (exp_kind == br_jreg)
            want_target = op1;
        else if (exp_kind != br_none)
            want_target = model_q.pc + 32'd4 + (offset << 2);
        want_stall = ex_fwd.is_load && ex_fwd.wr.we && ex_fwd.wr.waddr != '0 &&
                     ((exp_use1 && ex_fwd.wr.waddr == w.r.rs) ||
                      (exp_use2 && ex_fwd.wr.waddr == w.r.rt));
        checks++;
        if (id_to_ex.pc !== model_q.pc)
            report_mismatch("pc", 64'(id_to_ex.pc), 64'(model_q.pc));
        if (id_to_ex.inst !== inst_rdata)
            report_mismatch("inst", 64'(id_to_ex.inst), 64'(inst_rdata));
        if (ctrl_bits(id_to_ex) !== ctrl_bits(exp))
            report_mismatch("controls", 64'(ctrl_bits(id_to_ex)), 64'(ctrl_bits(exp)));
        if (id_to_ex.data1 !== op1)
            report_mismatch("data1", 64'(id_to_ex.data1), 64'(op1));
        if (id_to_ex.data2 !== op2)
            report_mismatch("data2", 64'(id_to_ex.data2), 64'(op2));
        if (br.taken !== want_taken)
            report_mismatch("br.taken", 64'(br.taken), 64'(want_taken));
        if (br.target !== want_target)
            report_mismatch("br.target", 64'(br.target), 64'(want_target));
        if (stall_load !== want_stall)
            report_mismatch("stall_load", 64'(stall_load), 64'(want_stall));
    endtask

    // what the next rising edge does to the stage register and register file
    task automatic advance_model();
        if (stall.id_stop && !stall.ex_stop)
            model_q = '0;
        else if (!stall.id_stop)
            model_q = fetch;
        if (wb.we && wb.waddr != '0)
            model_regs[wb.waddr] = wb.wdata;
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        fetch      = '0;
        stall      = '0;
        inst_rdata = '0;
        wb         = '0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        model_q    = '0;
        errors     = 0;
        checks     = 0;
        wait (!rst);
        @(negedge clk);
        for (int r = 1; r < 32; r++) begin   // give every register a known value
            wb.we         = 1'b1;
            wb.waddr      = 5'(r);
            wb.wdata      = take_bits(32);
            model_regs[r] = wb.wdata;
            @(negedge clk);
        end
        for (int n = 0; n < num_cycles; n++) begin
            drive_inputs();
            #1;
            check_outputs();
            advance_model();
            @(negedge clk);
        end
        $display("%0d cycles checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #((8 + fill_cycles + num_cycles + 50) * 10);
        $display("Watchdog expired before the test sequence finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;             // released on the 8th rising edge
    end

endmodule
